//--- source/rtg_pkg.sv
/*
 * RTG video output stage shared types
 * Width types for pixel words, colour channels and timing controls
 */
`default_nettype none

package rtg_pkg;

	////////////////////////////////////////////////////////////
	// Datapath widths
	////////////////////////////////////////////////////////////

	typedef logic [15:0] rtg_word_t;	// Pixel word, 5-5-5 or two CLUT indices
	typedef logic [7:0]  color_t;		// One output colour channel
	typedef logic [7:0]  clut_idx_t;	// Colour table index

	////////////////////////////////////////////////////////////
	// Timing controls
	////////////////////////////////////////////////////////////

	typedef logic [3:0]  pixel_width_t;	// Clocks per fetch minus one
	typedef logic [6:0]  vbend_t;		// Hsync edges in held vblank

endpackage : rtg_pkg

`default_nettype wire

//--- source/rtg_timing.sv
/*
 * RTG timing control
 * Fetch cadence, CLUT byte phase, held vblank and pixel strobes
 */
`timescale 1ns/100ps
`default_nettype none

module rtg_timing import rtg_pkg::*; (
	input  logic         CLK_114,
	input  logic         rst_n,
	input  logic         rtg_ena,
	input  logic         rtg_clut,
	input  logic         rtg_ext,
	input  logic         lowres,
	input  pixel_width_t pixel_width,
	input  vbend_t       vbend,
	input  logic         hblank,
	input  logic         vblank,
	input  logic         hsync,
	output logic         fetch,
	output logic         clut_lo_sel,
	output logic         blank_d2,
	output logic         vga_pixel
);

	typedef enum logic [1:0] {VB_OPEN, VB_HOLD, VB_COUNT} vb_state_t;

	vb_state_t    vb_state;
	vbend_t       vb_cnt;		// Hsync edges since vblank fell
	logic         hsync_d;
	logic         blank;
	logic         blank_d;
	pixel_width_t pix_ctr;		// Compared against pixel_width
	logic [2:0]   fetch_d;		// Fetch delay line, matches colour path
	logic [2:0]   sel_d;		// Byte phase delay line
	logic [2:0]   chip_ctr;
	logic         rtg_stb;

	////////////////////////////////////////////////////////////
	// Fetch cadence and CLUT byte phase
	////////////////////////////////////////////////////////////

	assign blank = hblank | (vb_state != VB_OPEN);
	// Extended line takes one extra fetch in the first blanked clock
	assign fetch = rtg_ena && (!blank || (!blank_d && rtg_ext)) && (pix_ctr == pixel_width);

	always_ff @(posedge CLK_114) begin
		if (!rst_n) begin
			pix_ctr     <= '0;
			clut_lo_sel <= 1'b0;
			blank_d     <= 1'b1;
			blank_d2    <= 1'b1;
		end else begin
			blank_d  <= blank;
			blank_d2 <= blank_d;		// To mixer source select
			if (blank || fetch) begin
				pix_ctr     <= '0;	// Restart per pixel
				clut_lo_sel <= 1'b0;	// Back to high byte
			end else begin
				pix_ctr <= pix_ctr + 4'd1;
				if (pix_ctr == (pixel_width >> 1))
					clut_lo_sel <= 1'b1;	// Second index half way
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Held vertical blank
	////////////////////////////////////////////////////////////

	always_ff @(posedge CLK_114) begin
		if (!rst_n) begin
			vb_state <= VB_OPEN;
			vb_cnt   <= '0;
			hsync_d  <= 1'b0;
		end else begin
			hsync_d <= hsync;
			if (vblank) begin
				vb_state <= VB_HOLD;		// Hold and clear count
				vb_cnt   <= '0;
			end else begin
				case (vb_state)
					VB_HOLD:  vb_state <= VB_COUNT;
					VB_COUNT: begin
						if (vb_cnt == vbend)
							vb_state <= VB_OPEN;	// Release blank
						else if (hsync && !hsync_d)
							vb_cnt <= vb_cnt + 7'd1;	// Rising edge only
					end
					default:  vb_state <= VB_OPEN;
				endcase
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Pixel strobes
	////////////////////////////////////////////////////////////

	always_ff @(posedge CLK_114) begin
		if (!rst_n) begin
			fetch_d  <= '0;
			sel_d    <= '0;
			chip_ctr <= 3'd1;		// Keeps strobe low out of reset
		end else begin
			fetch_d  <= {fetch_d[1:0], fetch};
			sel_d    <= {sel_d[1:0], clut_lo_sel};
			chip_ctr <= lowres ? {chip_ctr[2:1], 1'b0} + 3'd2 : chip_ctr + 3'd1;
		end
	end

	// Strobe lands in the cycle the new colour reaches the outputs
	// Table read adds one clock in CLUT mode
	assign rtg_stb   = rtg_clut ? (fetch_d[2] | (sel_d[1] & !sel_d[2])) : fetch_d[1];
	assign vga_pixel = rtg_ena ? rtg_stb : (chip_ctr == 3'd0);

endmodule : rtg_timing

`default_nettype wire

//--- source/rtg_word_fifo.sv
/*
 * RTG pixel word FIFO
 * Show-ahead circular buffer, strobe written, popped by fetch
 */
`timescale 1ns/100ps
`default_nettype none

module rtg_word_fifo import rtg_pkg::*; #(
	parameter int FIFO_DEPTH = 16		// Power of two, at least 4
) (
	input  logic      CLK_114,
	input  logic      rst_n,
	input  logic      rtg_ena,
	input  logic      word_stb,
	input  rtg_word_t word_data,
	input  logic      fetch,
	output rtg_word_t fifo_q,
	output logic      fifo_low
);

	localparam int AW = $clog2(FIFO_DEPTH);
	localparam int LW = AW + 1;			// Extra bit tells full from empty

	rtg_word_t        mem [FIFO_DEPTH];
	logic [LW-1:0]    wr_ptr;
	logic [LW-1:0]    rd_ptr;
	logic [LW-1:0]    level;
	logic             full;
	logic             empty;

	assign level    = wr_ptr - rd_ptr;
	assign full     = (level == LW'(FIFO_DEPTH));
	assign empty    = (level == '0);
	assign fifo_low = (level < LW'(FIFO_DEPTH / 2));	// Refill request to writer
	assign fifo_q   = mem[rd_ptr[AW-1:0]];			// Head word, show-ahead

	always_ff @(posedge CLK_114) begin
		if (word_stb && !full)
			mem[wr_ptr[AW-1:0]] <= word_data;
	end

	always_ff @(posedge CLK_114) begin
		if (!rst_n || !rtg_ena) begin
			wr_ptr <= '0;			// Flush while RTG is off
			rd_ptr <= '0;
		end else begin
			if (word_stb && !full)
				wr_ptr <= wr_ptr + LW'(1);	// Full drops the word
			if (fetch && !empty)
				rd_ptr <= rd_ptr + LW'(1);	// Pop on empty is ignored
		end
	end

endmodule : rtg_word_fifo

`default_nettype wire

//--- source/rtg_pixel_decode.sv
/*
 * RTG pixel decoder
 * Hi-colour 5-5-5 expansion and 256-entry colour lookup table
 */
`timescale 1ns/100ps
`default_nettype none

module rtg_pixel_decode import rtg_pkg::*; (
	input  logic      CLK_114,
	input  logic      rst_n,
	input  logic      rtg_clut,
	input  logic      fetch,
	input  logic      clut_lo_sel,
	input  rtg_word_t fifo_q,
	input  logic      clut_wr,
	input  clut_idx_t clut_wr_idx,
	input  color_t    clut_wr_r,
	input  color_t    clut_wr_g,
	input  color_t    clut_wr_b,
	output color_t    rtg_r,
	output color_t    rtg_g,
	output color_t    rtg_b
);

	rtg_word_t   word_q;		// Word taken on fetch
	clut_idx_t   rd_idx;
	logic [23:0] clut_mem [256];	// Packed r, g, b
	logic [23:0] clut_q;
	color_t      hc_r;
	color_t      hc_g;
	color_t      hc_b;

	always_ff @(posedge CLK_114) begin
		if (!rst_n)
			word_q <= '0;			// Black until first fetch
		else if (fetch)
			word_q <= fifo_q;
	end

	////////////////////////////////////////////////////////////
	// Colour table
	////////////////////////////////////////////////////////////

	// High byte first, low byte in second half of the pixel
	assign rd_idx = clut_lo_sel ? word_q[7:0] : word_q[15:8];

	always_ff @(posedge CLK_114) begin
		if (clut_wr)
			clut_mem[clut_wr_idx] <= {clut_wr_r, clut_wr_g, clut_wr_b};
	end

	always_ff @(posedge CLK_114) begin
		clut_q <= clut_mem[rd_idx];		// Registered read
	end

	////////////////////////////////////////////////////////////
	// Hi-colour expansion
	////////////////////////////////////////////////////////////

	// Top bits repeated so full scale maps to 8'hff
	assign hc_r = {word_q[14:10], word_q[14:12]};
	assign hc_g = {word_q[9:5],   word_q[9:7]};
	assign hc_b = {word_q[4:0],   word_q[4:2]};

	assign rtg_r = rtg_clut ? clut_q[23:16] : hc_r;
	assign rtg_g = rtg_clut ? clut_q[15:8]  : hc_g;
	assign rtg_b = rtg_clut ? clut_q[7:0]   : hc_b;

endmodule : rtg_pixel_decode

`default_nettype wire

//--- source/rtg_video_mixer.sv
/*
 * Video output mixer
 * Source select, output register, OSD overlay, sync polarity
 */
`timescale 1ns/100ps
`default_nettype none

module rtg_video_mixer import rtg_pkg::*; (
	input  logic   CLK_114,
	input  logic   rst_n,
	input  logic   rtg_ena,
	input  logic   blank_d2,
	input  color_t rtg_r,
	input  color_t rtg_g,
	input  color_t rtg_b,
	input  color_t chip_r,
	input  color_t chip_g,
	input  color_t chip_b,
	input  logic   osd_window,
	input  logic   osd_pixel,
	input  logic   hsync,
	input  logic   vsync,
	input  logic   hsyncpol,
	input  logic   vsyncpol,
	output color_t vga_r,
	output color_t vga_g,
	output color_t vga_b,
	output logic   vga_hs,
	output logic   vga_vs
);

	logic       use_rtg;
	color_t     red_q;
	color_t     grn_q;
	color_t     blu_q;
	logic [1:0] osd_rg;		// Same for red and green
	logic [1:0] osd_b;

	assign use_rtg = rtg_ena && !blank_d2;	// Chipset shows through in blank

	always_ff @(posedge CLK_114) begin
		if (!rst_n) begin
			red_q  <= '0;
			grn_q  <= '0;
			blu_q  <= '0;
			vga_hs <= 1'b0;
			vga_vs <= 1'b0;
		end else begin
			red_q  <= use_rtg ? rtg_r : chip_r;
			grn_q  <= use_rtg ? rtg_g : chip_g;
			blu_q  <= use_rtg ? rtg_b : chip_b;
			vga_hs <= hsync ^ hsyncpol;	// Polarity fix
			vga_vs <= vsync ^ vsyncpol;
		end
	end

	// OSD: white text on a dark blue tint
	assign osd_rg = osd_pixel ? 2'b11 : 2'b00;
	assign osd_b  = osd_pixel ? 2'b11 : 2'b10;

	assign vga_r = osd_window ? {osd_rg, red_q[7:2]} : red_q;
	assign vga_g = osd_window ? {osd_rg, grn_q[7:2]} : grn_q;
	assign vga_b = osd_window ? {osd_b,  blu_q[7:2]} : blu_q;

endmodule : rtg_video_mixer

`default_nettype wire

//--- tests/tb_rtg_checks.svh
/*
 * Testbench support for the RTG video stage
 * Clock, LFSR stimulus source, value compare and strobe wait
 */
`ifndef TB_RTG_CHECKS_SVH
`define TB_RTG_CHECKS_SVH

	logic [31:0] lfsr_state = 32'h65847e7a;	// Fixed seed

	initial begin
		CLK_114 = 1'b0;
		forever #50 CLK_114 = ~CLK_114;	// 100 ns period
	end

	// Galois LFSR, x^32+x^22+x^2+x+1, one step per bit taken
	function automatic logic [31:0] rand_bits(input int nbits);
		logic [31:0] val;
		val = '0;
		for (int i = 0; i < nbits; i++) begin
			val = {val[30:0], lfsr_state[0]};
			lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003) : (lfsr_state >> 1);
		end
		return val;
	endfunction

	task automatic fail_now(input string what);
		$display("%s", what);
		$display("Verification failed");
		$fatal(1, "Run stopped at first error");
	endtask

	task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] want);
		if (got !== want)
			fail_now($sformatf("Error: %s = 0x%h, expected 0x%h", name, got, want));
	endtask

	task automatic check_rgb(input logic [23:0] want);
		check_eq("vga_r", 32'(vga_r), 32'(want[23:16]));
		check_eq("vga_g", 32'(vga_g), 32'(want[15:8]));
		check_eq("vga_b", 32'(vga_b), 32'(want[7:0]));
	endtask

	////////////////////////////////////////////////////////////
	// Cycle steps and waits
	////////////////////////////////////////////////////////////

	task automatic next_edge();
		@(posedge CLK_114);
		#1;				// Drive point just after the edge
	endtask

	task automatic settle();
		@(negedge CLK_114);		// Sample point, outputs stable
	endtask

	// Counts cycles until the next pixel strobe
	task automatic wait_strobe(input int limit, output int waited);
		waited = 0;
		do begin
			@(negedge CLK_114);
			waited++;
			if (waited > limit)
				fail_now("Timed out waiting for a pixel strobe");
		end while (!vga_pixel);
	endtask

`endif

//--- tests/tb_rtg_video.sv
/*
 * Testbench for the RTG video output stage
 * Directed tests for chipset, hi-colour, CLUT, held vblank, OSD and FIFO flag
 */
`timescale 1ns/100ps
`default_nettype none

module tb_rtg_video import rtg_pkg::*; ();

	localparam int DEPTH = 16;

	logic         CLK_114;
	logic         rst_n;
	logic         rtg_ena;
	logic         rtg_clut;
	logic         rtg_ext;
	logic         lowres;
	pixel_width_t pixel_width;
	vbend_t       vbend;
	logic         hblank;
	logic         vblank;
	logic         hsync;
	logic         vsync;
	logic         word_stb;
	rtg_word_t    word_data;
	logic         clut_wr;
	clut_idx_t    clut_wr_idx;
	color_t       clut_wr_r;
	color_t       clut_wr_g;
	color_t       clut_wr_b;
	color_t       chip_r;
	color_t       chip_g;
	color_t       chip_b;
	logic         osd_window;
	logic         osd_pixel;
	logic         hsyncpol;
	logic         vsyncpol;
	logic         vga_pixel;
	color_t       vga_r;
	color_t       vga_g;
	color_t       vga_b;
	logic         vga_hs;
	logic         vga_vs;
	logic         fifo_low;

	rtg_video_top #(.FIFO_DEPTH(DEPTH)) u_dut (.*);

	`include "tb_rtg_checks.svh"

	////////////////////////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////////////////////////

	// 5-5-5 to 8-8-8 with the top three bits of each field repeated
	function automatic logic [23:0] expand555(input rtg_word_t w);
		return {w[14:10], w[14:12], w[9:5], w[9:7], w[4:0], w[4:2]};
	endfunction

	task automatic write_word(input rtg_word_t w);
		word_stb  = 1'b1;
		word_data = w;
		next_edge();
		word_stb  = 1'b0;
	endtask

	task automatic load_clut(input clut_idx_t idx, input logic [23:0] rgb);
		clut_wr     = 1'b1;
		clut_wr_idx = idx;
		{clut_wr_r, clut_wr_g, clut_wr_b} = rgb;
		next_edge();
		clut_wr     = 1'b0;
	endtask

	task automatic prepare_rtg(input logic clut);
		hblank   = 1'b1;
		rtg_ena  = 1'b0;		// Empties the FIFO
		rtg_clut = clut;
		next_edge();
		next_edge();
		rtg_ena  = 1'b1;
	endtask

	// Hsync pulse with vga_pixel held low throughout
	task automatic hsync_pulse(input int high_cycles, input int low_cycles);
		for (int i = 0; i < high_cycles + low_cycles; i++) begin
			hsync = (i < high_cycles);
			settle();
			check_eq("vga_pixel", 32'(vga_pixel), 32'd0);
			next_edge();
		end
	endtask

	////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////

	task automatic test_reset_chipset();
		int          gap;
		logic [23:0] c;
		settle();				// First cycle after reset
		check_eq("vga_pixel", 32'(vga_pixel), 32'd0);
		check_rgb(24'd0);
		check_eq("fifo_low", 32'(fifo_low), 32'd1);
		for (int l = 0; l < 2; l++) begin
			next_edge();
			lowres = l[0];
			wait_strobe(20, gap);		// Align to the counter
			wait_strobe(20, gap);
			check_eq("chipset strobe gap", 32'(gap), l ? 32'd4 : 32'd8);
		end
		repeat (4) begin
			next_edge();
			c = 24'(rand_bits(24));
			{chip_r, chip_g, chip_b} = c;
			next_edge();			// Output register takes it here
			settle();
			check_rgb(c);
		end
		next_edge();
		lowres = 1'b0;
	endtask

	task automatic test_hicolour();
		rtg_word_t words [8];
		int        gap;
		prepare_rtg(1'b0);
		for (int i = 0; i < 8; i++) begin
			words[i] = 16'(rand_bits(16));
			write_word(words[i]);
		end
		hblank = 1'b0;				// Active line
		wait_strobe(30, gap);
		check_rgb(expand555(words[0]));
		for (int i = 1; i < 8; i++) begin
			wait_strobe(10, gap);
			check_eq("rtg strobe gap", 32'(gap), 32'd4);	// pixel_width 3
			check_rgb(expand555(words[i]));
		end
		next_edge();
		hblank = 1'b1;
	endtask

	task automatic test_clut();
		logic [23:0] clut_model [256];
		rtg_word_t   words [8];
		clut_idx_t   idx;
		int          gap;
		prepare_rtg(1'b1);
		for (int i = 0; i < 8; i++) begin
			words[i] = 16'(rand_bits(16));
			for (int k = 0; k < 2; k++) begin
				idx = k ? words[i][7:0] : words[i][15:8];
				clut_model[idx] = 24'(rand_bits(24));	// Later write wins
				load_clut(idx, clut_model[idx]);
			end
		end
		for (int i = 0; i < 8; i++)
			write_word(words[i]);
		hblank = 1'b0;
		// Byte phase rises once before the first fetch on a stale word
		wait_strobe(30, gap);
		for (int i = 0; i < 8; i++) begin
			wait_strobe(10, gap);
			check_rgb(clut_model[words[i][15:8]]);	// High byte first
			wait_strobe(10, gap);
			check_rgb(clut_model[words[i][7:0]]);
		end
		next_edge();
		hblank   = 1'b1;
		rtg_clut = 1'b0;
	endtask

	task automatic test_held_vblank();
		int gap;
		prepare_rtg(1'b0);
		vbend  = 7'd3;
		vblank = 1'b1;
		repeat (8)
			write_word(16'(rand_bits(16)));
		hblank = 1'b0;
		vblank = 1'b0;				// Edge count starts
		hsync_pulse(0, 4);
		hsync_pulse(2, 6);
		hsync_pulse(2, 6);
		hsync_pulse(2, 0);			// Third rising edge
		hsync = 1'b0;
		wait_strobe(30, gap);			// Fetches resume
		next_edge();
		hblank = 1'b1;
	endtask

	task automatic test_osd_sync();
		logic [23:0] c;
		logic [1:0]  top_rg;
		logic [1:0]  top_b;
		next_edge();
		rtg_ena = 1'b0;
		c = 24'(rand_bits(24));
		{chip_r, chip_g, chip_b} = c;
		for (int p = 0; p < 2; p++) begin
			osd_window = 1'b1;
			osd_pixel  = p[0];
			next_edge();
			settle();
			top_rg = p ? 2'b11 : 2'b00;	// White text or dark tint
			top_b  = p ? 2'b11 : 2'b10;
			check_rgb({top_rg, c[23:18], top_rg, c[15:10], top_b, c[7:2]});
			next_edge();
		end
		osd_window = 1'b0;
		osd_pixel  = 1'b0;
		settle();
		check_rgb(c);
		for (int i = 0; i < 16; i++) begin
			next_edge();
			{hsync, vsync, hsyncpol, vsyncpol} = 4'(i);
			next_edge();
			settle();
			check_eq("vga_hs", 32'(vga_hs), 32'(hsyncpol ? !hsync : hsync));
			check_eq("vga_vs", 32'(vga_vs), 32'(vsyncpol ? !vsync : vsync));
		end
		next_edge();
		{hsync, vsync, hsyncpol, vsyncpol} = 4'd0;
	endtask

	task automatic test_fifo_flag();
		prepare_rtg(1'b0);			// Blanked so nothing is popped
		settle();
		check_eq("fifo_low", 32'(fifo_low), 32'd1);
		for (int n = 1; n <= 12; n++) begin
			next_edge();
			write_word(16'(rand_bits(16)));
			settle();
			check_eq("fifo_low", 32'(fifo_low), 32'(n < DEPTH / 2));
		end
		next_edge();
		rtg_ena = 1'b0;
		next_edge();
		settle();
		check_eq("fifo_low", 32'(fifo_low), 32'd1);	// Flushed
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////

	initial begin
		rst_n       = 1'b0;
		rtg_ena     = 1'b0;
		rtg_clut    = 1'b0;
		rtg_ext     = 1'b0;
		lowres      = 1'b0;
		pixel_width = 4'd3;
		vbend       = 7'd0;
		hblank      = 1'b1;
		vblank      = 1'b0;
		hsync       = 1'b0;
		vsync       = 1'b0;
		word_stb    = 1'b0;
		word_data   = '0;
		clut_wr     = 1'b0;
		clut_wr_idx = '0;
		clut_wr_r   = '0;
		clut_wr_g   = '0;
		clut_wr_b   = '0;
		chip_r      = '0;
		chip_g      = '0;
		chip_b      = '0;
		osd_window  = 1'b0;
		osd_pixel   = 1'b0;
		hsyncpol    = 1'b0;
		vsyncpol    = 1'b0;
		repeat (16) @(posedge CLK_114);
		#1;
		rst_n = 1'b1;
		test_reset_chipset();
		test_hicolour();
		test_clut();
		test_held_vblank();
		test_osd_sync();
		test_fifo_flag();
		$display("Verification passed");
		$finish;
	end

endmodule : tb_rtg_video

`default_nettype wire

//--- source/rtg_video_top.sv
/*
 * RTG video output stage top level
 * Timing, word FIFO, pixel decoder and output mixer
 */
`timescale 1ns/100ps
`default_nettype none

module rtg_video_top import rtg_pkg::*; #(
	parameter int FIFO_DEPTH = 16
) (
	input  logic         CLK_114,
	input  logic         rst_n,
	input  logic         rtg_ena,
	input  logic         rtg_clut,
	input  logic         rtg_ext,
	input  logic         lowres,
	input  pixel_width_t pixel_width,
	input  vbend_t       vbend,
	input  logic         hblank,
	input  logic         vblank,
	input  logic         hsync,
	input  logic         vsync,
	input  logic         word_stb,
	input  rtg_word_t    word_data,
	input  logic         clut_wr,
	input  clut_idx_t    clut_wr_idx,
	input  color_t       clut_wr_r,
	input  color_t       clut_wr_g,
	input  color_t       clut_wr_b,
	input  color_t       chip_r,
	input  color_t       chip_g,
	input  color_t       chip_b,
	input  logic         osd_window,
	input  logic         osd_pixel,
	input  logic         hsyncpol,
	input  logic         vsyncpol,
	output logic         vga_pixel,
	output color_t       vga_r,
	output color_t       vga_g,
	output color_t       vga_b,
	output logic         vga_hs,
	output logic         vga_vs,
	output logic         fifo_low
);

	logic      fetch;		// Pop and latch strobe
	logic      clut_lo_sel;
	logic      blank_d2;
	rtg_word_t fifo_q;
	color_t    rtg_r;
	color_t    rtg_g;
	color_t    rtg_b;

	rtg_timing u_timing (
		.CLK_114(CLK_114), .rst_n(rst_n), .rtg_ena(rtg_ena), .rtg_clut(rtg_clut),
		.rtg_ext(rtg_ext), .lowres(lowres), .pixel_width(pixel_width), .vbend(vbend),
		.hblank(hblank), .vblank(vblank), .hsync(hsync), .fetch(fetch),
		.clut_lo_sel(clut_lo_sel), .blank_d2(blank_d2), .vga_pixel(vga_pixel)
	);

	rtg_word_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
		.CLK_114(CLK_114), .rst_n(rst_n), .rtg_ena(rtg_ena), .word_stb(word_stb),
		.word_data(word_data), .fetch(fetch), .fifo_q(fifo_q), .fifo_low(fifo_low)
	);

	rtg_pixel_decode u_decode (
		.CLK_114(CLK_114), .rst_n(rst_n), .rtg_clut(rtg_clut), .fetch(fetch),
		.clut_lo_sel(clut_lo_sel), .fifo_q(fifo_q), .clut_wr(clut_wr),
		.clut_wr_idx(clut_wr_idx), .clut_wr_r(clut_wr_r), .clut_wr_g(clut_wr_g),
		.clut_wr_b(clut_wr_b), .rtg_r(rtg_r), .rtg_g(rtg_g), .rtg_b(rtg_b)
	);

	rtg_video_mixer u_mixer (
		.CLK_114(CLK_114), .rst_n(rst_n), .rtg_ena(rtg_ena), .blank_d2(blank_d2),
		.rtg_r(rtg_r), .rtg_g(rtg_g), .rtg_b(rtg_b),
		.chip_r(chip_r), .chip_g(chip_g), .chip_b(chip_b),
		.osd_window(osd_window), .osd_pixel(osd_pixel), .hsync(hsync), .vsync(vsync),
		.hsyncpol(hsyncpol), .vsyncpol(vsyncpol),
		.vga_r(vga_r), .vga_g(vga_g), .vga_b(vga_b), .vga_hs(vga_hs), .vga_vs(vga_vs)
	);

endmodule : rtg_video_top

`default_nettype wire

//--- tb.f
+incdir+tests
source/rtg_pkg.sv
source/rtg_timing.sv
source/rtg_word_fifo.sv
source/rtg_pixel_decode.sv
source/rtg_video_mixer.sv
tests/tb_rtg_video.sv
source/rtg_video_top.sv

//--- Makefile
# Verilator simulation of the RTG video output stage
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = tb_rtg_video
FILELIST  = tb.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

# Pass only if the log holds the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^Verification passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
